// File: src/isa_pkg.sv
/*
 * Instruction-set definitions for the 16-bit code word: field widths,
 * instruction classes, ALU opcodes and the decoded-instruction struct.
 */
package isa_pkg;

   localparam int code_w     = 16;
   localparam int reg_addr_w = 4;
   localparam int imm_w      = 8;
   localparam int tgt_w      = 8;   // full jump target, pc may use fewer bits

   // top nibble of the code; any code with bit 15 clear is alu_class
   typedef enum logic [2:0] {
      alu_class = 3'd0,
      jz        = 3'd1,   // 1000
      jnz       = 3'd2,   // 1001
      loadi     = 3'd3,   // 1010
      jnc       = 3'd4,   // 1011
      jc        = 3'd5,   // 1100
      stop      = 3'd6,   // 1111
      nop       = 3'd7    // reserved patterns
   } class_e;

   // code bits 14:12 for ALU instructions
   typedef enum logic [2:0] {
      op_sll  = 3'b000,
      op_srl  = 3'b001,
      op_add  = 3'b010,
      op_sub  = 3'b011,
      op_and  = 3'b100,
      op_xnor = 3'b101
   } alu_op_e;

   typedef struct packed {
      class_e                cls;
      alu_op_e               op;
      logic [reg_addr_w-1:0] dest;
      logic [reg_addr_w-1:0] src_a;
      logic [reg_addr_w-1:0] src_b;
      logic [imm_w-1:0]      imm;
      logic [tgt_w-1:0]      target;
   } decoded_t;

endpackage

// File: src/core_pkg.sv
/*
 * Micro-architecture definitions: sequencer states and the result
 * structs passed between ALU, branch unit, sequencer and register file.
 */
package core_pkg;

   localparam int word_w = 32;   // widest supported data path

   typedef enum logic [1:0] {
      s_req     = 2'd0,
      s_release = 2'd1,
      s_exec    = 2'd2,
      s_halt    = 2'd3
   } seq_state_e;

   typedef struct packed {
      logic [word_w-1:0] data;
      logic              carry;   // add/sub only
   } alu_res_t;

   typedef struct packed {
      logic                     take;
      logic [isa_pkg::tgt_w-1:0] target;
   } br_res_t;

   typedef struct packed {
      logic                          we;
      logic [isa_pkg::reg_addr_w-1:0] addr;
      logic [word_w-1:0]             data;
   } wb_t;

endpackage

// File: src/instr_decoder.sv
/*
 * Instruction decoder. Classifies the top nibble of the code word and
 * extracts opcode, register fields, immediate and split jump target.
 */
`timescale 1ns/100ps

module instr_decoder (
   input  logic [isa_pkg::code_w-1:0] code,
   output isa_pkg::decoded_t          dec
);
   import isa_pkg::*;

   logic op_legal;

   assign op_legal = (code[14:12] <= 3'b101);   // 110 and 111 reserved

   always_comb begin
      dec = '0;

      casez (code[15:12])
         4'b0???: dec.cls = op_legal ? alu_class : nop;
         4'b1000: dec.cls = jz;
         4'b1001: dec.cls = jnz;
         4'b1010: dec.cls = loadi;
         4'b1011: dec.cls = jnc;
         4'b1100: dec.cls = jc;
         4'b1111: dec.cls = stop;
         default: dec.cls = nop;   // 1101, 1110
      endcase

      if (op_legal) begin
         dec.op = alu_op_e'(code[14:12]);
      end else begin
         dec.op = op_sll;
      end

      dec.dest   = code[11:8];
      dec.src_a  = code[7:4];   // also the register tested by jz/jnz
      dec.src_b  = code[3:0];
      dec.imm    = code[7:0];
      dec.target = {code[11:8], code[3:0]};
   end

   // unknown code bits must not turn into an undefined class
   always_comb begin
      assert final (!$isunknown(dec.cls))
         else $error("instr_decoder: class unknown for code %h", code);
   end

endmodule

// File: src/reg_file.sv
/*
 * Register file, sixteen words with two combinational read ports and
 * one write port fed by the sequencer write-back.
 */
`timescale 1ns/100ps

module reg_file #(
   parameter int data_w = 32
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic [isa_pkg::reg_addr_w-1:0] addr_a,
   input  logic [isa_pkg::reg_addr_w-1:0] addr_b,
   output logic [data_w-1:0]             rd_a,
   output logic [data_w-1:0]             rd_b,
   input  core_pkg::wb_t                 wb
);
   import isa_pkg::*;

   localparam int n_regs = 1 << reg_addr_w;

   logic [data_w-1:0] regs [n_regs];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         regs <= '{default: '0};
      end else if (wb.we) begin
         regs[wb.addr] <= wb.data[data_w-1:0];
      end
   end

   assign rd_a = regs[addr_a];
   assign rd_b = regs[addr_b];

   // write-back from the sequencer must name a real register
   a_wb_addr_known: assert property (
      @(posedge clk) disable iff (!arst_n)
      wb.we |-> !$isunknown(wb.addr)
   ) else $error("reg_file: write with unknown address");

endmodule

// File: src/alu.sv
/*
 * ALU: logical shifts, add and subtract with carry-out, AND and XNOR.
 * Subtract inverts b and adds one, so carry set means no borrow.
 */
`timescale 1ns/100ps

module alu #(
   parameter int data_w = 32
) (
   input  logic [data_w-1:0] a,
   input  logic [data_w-1:0] b,
   input  isa_pkg::alu_op_e  op,
   output core_pkg::alu_res_t res
);
   import isa_pkg::*;
   import core_pkg::*;

   logic              sub;
   logic [data_w-1:0] b_eff;
   logic [data_w:0]   sum;    // extra bit is the carry
   logic [data_w-1:0] y;

   assign sub   = (op == op_sub);
   assign b_eff = sub ? ~b : b;
   assign sum   = {1'b0, a} + {1'b0, b_eff} + sub;

   always_comb begin
      y = '0;
      case (op)
         op_sll:  y = a << b[4:0];
         op_srl:  y = a >> b[4:0];
         op_add,
         op_sub:  y = sum[data_w-1:0];
         op_and:  y = a & b;
         op_xnor: y = ~(a ^ b);
         default: y = '0;
      endcase
   end

   assign res.data  = word_w'(y);
   assign res.carry = sum[data_w];

endmodule

// File: src/branch_unit.sv
/*
 * Branch unit. Tests operand a for zero, holds the carry flag from the
 * last add or subtract and decides whether a jump is taken.
 */
`timescale 1ns/100ps

module branch_unit #(
   parameter int data_w = 32
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic [data_w-1:0] a,
   input  isa_pkg::decoded_t dec,
   input  logic              alu_carry,
   input  logic              exec,
   output core_pkg::br_res_t br
);
   import isa_pkg::*;

   logic carry_q;
   logic a_zero;
   logic arith;

   assign a_zero = (a == '0);
   assign arith  = (dec.cls == alu_class) && (dec.op inside {op_add, op_sub});

   // flag only moves on add/sub
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         carry_q <= 1'b0;
      end else if (exec && arith) begin
         carry_q <= alu_carry;
      end
   end

   always_comb begin
      case (dec.cls)
         jz:      br.take = a_zero;
         jnz:     br.take = !a_zero;
         jc:      br.take = carry_q;
         jnc:     br.take = !carry_q;
         default: br.take = 1'b0;
      endcase
      br.target = dec.target;
   end

   // jump decision rests on a known operand and flag
   a_take_known: assert property (
      @(posedge clk) disable iff (!arst_n)
      exec |-> !$isunknown(br.take)
   ) else $error("branch_unit: jump decision unknown during execute");

endmodule

// File: src/sequencer.sv
/*
 * Sequencer. Runs the four-phase fetch with the instruction memory,
 * holds the code word and pc, builds the write-back and stops on STOP.
 */
`timescale 1ns/100ps

module sequencer #(
   parameter int data_w = 32,
   parameter int pc_w   = 8
) (
   input  logic                       clk,
   input  logic                       arst_n,
   output logic                       fetch_req,
   output logic [pc_w-1:0]            fetch_pc,
   input  logic [isa_pkg::code_w-1:0] fetch_code,
   input  logic                       fetch_ack,
   output logic [isa_pkg::code_w-1:0] code,
   input  isa_pkg::decoded_t          dec,
   input  core_pkg::alu_res_t         alu_res,
   input  core_pkg::br_res_t          br,
   output logic                       exec,
   output core_pkg::wb_t              wb,
   output logic                       halted
);
   import isa_pkg::*;
   import core_pkg::*;

   seq_state_e        state;
   logic [pc_w-1:0]   pc;
   logic [data_w-1:0] wb_word;
   logic              wb_we;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= s_req;
         fetch_req <= 1'b0;
         pc        <= '0;
         code      <= '0;
      end else begin
         case (state)
            s_req: begin
               if (!fetch_req) begin
                  fetch_req <= 1'b1;
               end else if (fetch_ack) begin
                  code      <= fetch_code;
                  fetch_req <= 1'b0;
                  state     <= s_release;
               end
            end
            s_release: if (!fetch_ack) state <= s_exec;   // wait for ack low
            s_exec: begin
               if (dec.cls == stop) begin
                  state <= s_halt;   // pc stays on the STOP
               end else begin
                  state <= s_req;
                  pc    <= br.take ? br.target[pc_w-1:0] : pc + 1'b1;
               end
            end
            default: state <= s_halt;   // only reset leaves here
         endcase
      end
   end

   assign fetch_pc = pc;
   assign exec     = (state == s_exec);
   assign halted   = (state == s_halt);

   always_comb begin
      wb_we   = 1'b0;
      wb_word = '0;
      if (exec) begin
         case (dec.cls)
            alu_class: begin
               wb_we   = 1'b1;
               wb_word = alu_res.data[data_w-1:0];
            end
            loadi: begin
               wb_we   = 1'b1;
               wb_word = data_w'(dec.imm);   // zero-extended
            end
            default: wb_we = 1'b0;
         endcase
      end
      wb.we   = wb_we;
      wb.addr = dec.dest;
      wb.data = word_w'(wb_word);
   end

   // a new request waits until the previous ack has gone
   a_no_req_over_ack: assert property (
      @(posedge clk) disable iff (!arst_n)
      fetch_ack && !fetch_req |=> !fetch_req
   ) else $error("sequencer: fetch_req raised while fetch_ack high");

   a_pc_stable: assert property (
      @(posedge clk) disable iff (!arst_n)
      fetch_req |=> $stable(fetch_pc)
   ) else $error("sequencer: fetch_pc moved during a request");

endmodule

// File: src/cpu_core.sv
/*
 * CPU core top level. Connects decoder, register file, ALU, branch
 * unit and sequencer; one instruction in flight at a time.
 */
`timescale 1ns/100ps

module cpu_core #(
   parameter int data_w = 32,
   parameter int pc_w   = 8
) (
   input  logic                           clk,
   input  logic                           arst_n,
   output logic                           fetch_req,
   output logic [pc_w-1:0]                fetch_pc,
   input  logic [isa_pkg::code_w-1:0]     fetch_code,
   input  logic                           fetch_ack,
   output logic                           wb_valid,
   output logic [isa_pkg::reg_addr_w-1:0] wb_addr,
   output logic [data_w-1:0]              wb_data,
   output logic                           halted
);
   import isa_pkg::*;
   import core_pkg::*;

   logic [code_w-1:0] code;
   decoded_t          dec;
   logic [data_w-1:0] rd_a;
   logic [data_w-1:0] rd_b;
   alu_res_t          alu_res;
   br_res_t           br;
   wb_t               wb;
   logic              exec;

   instr_decoder u_dec (
      .code (code),
      .dec  (dec)
   );

   reg_file #(.data_w(data_w)) u_rf (
      .clk    (clk),
      .arst_n (arst_n),
      .addr_a (dec.src_a),
      .addr_b (dec.src_b),
      .rd_a   (rd_a),
      .rd_b   (rd_b),
      .wb     (wb)
   );

   alu #(.data_w(data_w)) u_alu (
      .a   (rd_a),
      .b   (rd_b),
      .op  (dec.op),
      .res (alu_res)
   );

   branch_unit #(.data_w(data_w)) u_br (
      .clk       (clk),
      .arst_n    (arst_n),
      .a         (rd_a),
      .dec       (dec),
      .alu_carry (alu_res.carry),
      .exec      (exec),
      .br        (br)
   );

   sequencer #(.data_w(data_w), .pc_w(pc_w)) u_seq (
      .clk        (clk),
      .arst_n     (arst_n),
      .fetch_req  (fetch_req),
      .fetch_pc   (fetch_pc),
      .fetch_code (fetch_code),
      .fetch_ack  (fetch_ack),
      .code       (code),
      .dec        (dec),
      .alu_res    (alu_res),
      .br         (br),
      .exec       (exec),
      .wb         (wb),
      .halted     (halted)
   );

   // observation of the committed write-back
   assign wb_valid = wb.we;
   assign wb_addr  = wb.addr;
   assign wb_data  = wb.data[data_w-1:0];

endmodule

// File: testbench/clock_gen.sv
/*
 * Testbench clock and reset. Free-running clk, active-low reset held
 * for a number of cycles at start and after each reset request.
 */
`timescale 1ns/100ps

module clock_gen #(
   parameter int period_ns    = 40,
   parameter int reset_cycles = 5
) (
   input  logic reset_req,   // sampled on the falling edge
   output logic clk,
   output logic arst_n
);
   int count = reset_cycles;

   initial begin
      clk    = 1'b0;
      arst_n = 1'b0;
   end

   always #(period_ns / 2) clk = ~clk;

   // reset moves only on falling edges, away from the DUT's rising edge
   always @(negedge clk) begin
      if (reset_req) begin
         count  <= reset_cycles;
         arst_n <= 1'b0;
      end else if (count > 1) begin
         count <= count - 1;
      end else if (count == 1) begin
         count  <= 0;
         arst_n <= 1'b1;
      end
   end

endmodule

// File: testbench/tb_cpu.sv
/*
 * Testbench for cpu_core. Runs the programs of cpu_vectors.txt through an
 * instruction memory with random ack delay and checks every write-back.
 */
`timescale 1ns/100ps

module tb_cpu;

   localparam int prog_depth       = 256;
   localparam int vec_depth        = 1024;
   localparam int cycles_per_instr = 8;
   localparam int cycle_slack      = 100;
   localparam int idle_cycles      = 8;   // watched after STOP

   logic        clk;
   logic        arst_n;
   logic        reset_req;
   logic        fetch_req;
   logic [7:0]  fetch_pc;
   logic [15:0] fetch_code;
   logic        fetch_ack;
   logic        wb_valid;
   logic [3:0]  wb_addr;
   logic [31:0] wb_data;
   logic        halted;

   logic [31:0] vec [vec_depth];
   logic [15:0] imem [prog_depth];
   integer      seed = 32'h9eb2;
   integer      rnd;
   logic [1:0]  delay_left = 2'd0;
   logic        waiting = 1'b0;
   int          error_count = 0;
   int          check_count = 0;
   int          cycle_count = 0;
   int          cycle_limit = 0;

   clock_gen #(.period_ns(40), .reset_cycles(5)) u_clk (
      .reset_req (reset_req),
      .clk       (clk),
      .arst_n    (arst_n)
   );

   cpu_core #(.data_w(32), .pc_w(8)) DUT (
      .clk        (clk),
      .arst_n     (arst_n),
      .fetch_req  (fetch_req),
      .fetch_pc   (fetch_pc),
      .fetch_code (fetch_code),
      .fetch_ack  (fetch_ack),
      .wb_valid   (wb_valid),
      .wb_addr    (wb_addr),
      .wb_data    (wb_data),
      .halted     (halted)
   );

   // instruction memory, ack after 0 to 3 falling edges
   always @(negedge clk) begin
      if (!arst_n) begin
         fetch_ack <= 1'b0;
         waiting   = 1'b0;
      end else if (fetch_req && !fetch_ack) begin
         if (!waiting) begin
            rnd        = $random(seed);
            delay_left = rnd[1:0];
            waiting    = 1'b1;
         end
         if (delay_left == 2'd0) begin
            fetch_code <= imem[fetch_pc];
            fetch_ack  <= 1'b1;
            waiting    = 1'b0;
         end else begin
            delay_left = delay_left - 2'd1;
         end
      end else if (!fetch_req && fetch_ack) begin
         fetch_ack <= 1'b0;   // phase 4
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("Timeout: the programs did not finish within %0d cycles", cycle_limit);
         $display("Checks failed");
         $finish;
      end
   end

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
      check_count++;
      if (got !== expected) begin
         error_count++;
         $display("Error at %0t: %s is %h, expected %h", $time, what, got, expected);
      end
   endtask

   initial begin
      int p;
      int n_prog;
      int n_wb;
      int halt_pc;
      int wb_base;
      int wb_seen;
      int total_words;
      int test_no;
      int errors_before;

      reset_req  = 1'b0;
      fetch_ack  = 1'b0;
      fetch_code = '0;
      foreach (vec[i]) vec[i] = '0;
      $readmemh("cpu_vectors.txt", vec);

      // size the timeout from all program words
      p           = 0;
      total_words = 0;
      while (p + 3 <= vec_depth && vec[p] != 0) begin
         total_words += vec[p];
         p += 3 + vec[p] + 2 * vec[p + 1];
      end
      cycle_limit = total_words * cycles_per_instr + cycle_slack;
      if (total_words == 0) begin
         $display("No test program was found in cpu_vectors.txt");
         error_count++;
      end

      p       = 0;
      test_no = 0;
      while (p + 3 <= vec_depth && vec[p] != 0) begin
         n_prog        = vec[p];
         n_wb          = vec[p + 1];
         halt_pc       = vec[p + 2];
         wb_base       = p + 3 + n_prog;
         test_no++;
         errors_before = error_count;

         @(negedge clk) reset_req <= 1'b1;
         @(negedge clk) reset_req <= 1'b0;
         for (int a = 0; a < prog_depth; a++) begin
            imem[a] = (a < n_prog) ? vec[p + 3 + a][15:0] : (16'hD000 | 16'(a));
         end
         @(negedge clk);
         check_value("fetch_req in reset", fetch_req, 1'b0);
         check_value("wb_valid in reset", wb_valid, 1'b0);
         check_value("halted in reset", halted, 1'b0);
         check_value("pc in reset", fetch_pc, 0);
         wait (arst_n === 1'b1);

         wb_seen = 0;
         while (!halted) begin
            @(negedge clk);
            if (wb_valid) begin
               if (wb_seen < n_wb) begin
                  check_value("write-back address", wb_addr, vec[wb_base + 2 * wb_seen]);
                  check_value("write-back data", wb_data, vec[wb_base + 2 * wb_seen + 1]);
               end else begin
                  $display("Test %0d wrote register %0d after its last expected write-back",
                           test_no, wb_addr);
                  error_count++;
               end
               wb_seen++;
            end
         end

         if (wb_seen < n_wb) begin
            $display("Test %0d stopped after %0d of %0d expected write-backs",
                     test_no, wb_seen, n_wb);
            error_count++;
         end
         check_value("halt pc", fetch_pc, halt_pc);
         repeat (idle_cycles) begin
            @(negedge clk);
            check_value("fetch_req after STOP", fetch_req, 1'b0);
            check_value("halted after STOP", halted, 1'b1);
         end
         $display("test %0d: %0d program words, %0d write-backs, %0d errors",
                  test_no, n_prog, wb_seen, error_count - errors_before);
         p = wb_base + 2 * n_wb;
      end

      $display("%0d tests, %0d checks, %0d errors", test_no, check_count, error_count);
      if (error_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// File: list.f
src/isa_pkg.sv
src/core_pkg.sv
src/instr_decoder.sv
src/reg_file.sv
src/alu.sv
src/branch_unit.sv
src/sequencer.sv
src/cpu_core.sv
testbench/clock_gen.sv
testbench/tb_cpu.sv

// File: cpu_vectors.txt
// per test: program words, expected write-backs, halt pc; then the program
// words; then the expected write-backs as register/data pairs; 0 0 0 ends
// test 1: load immediate
4 3 3
A1FF A57E AF00 F000
1 000000FF 5 0000007E F 00000000
// test 2: sll, srl, add, sub, and, xnor, shift by low five bits
A 9 9
A1F0 A204 0312 1412 2512 3621 4713 5814 0911 F000
1 000000F0 2 00000004 3 00000F00 4 0000000F 5 000000F4
6 FFFFFF14 7 00000000 8 FFFFFF00 9 00F00000
// test 3: carry from add and sub, jc and jnc, logic ops keep carry
12 8 11
A101 5200 2321 4412 C007 A9EE A9EE 3511 B00C 2611 5711 C00F B00E A8AA 3812 B111 AAAA F000
1 00000001 2 FFFFFFFF 3 00000000 4 00000001 5 00000000 6 00000002 7 FFFFFFFF 8 00000002
// test 4: jz and jnz taken and not taken
D 3 A
A105 8004 A2AA A2BB 8016 A203 9018 A3CC 900B A30D F000 A4EE F000
1 00000005 2 00000003 3 0000000D
// test 5: STOP after a jump, word behind it never runs
7 1 5
A111 8005 A2AA A2BB A2CC F000 A3FF
1 00000011
// test 6: reserved ALU ops and top-level codes act as no-operation
8 3 7
A107 6211 7311 D123 E456 A209 2312 F000
1 00000007 2 00000009 3 00000010
0 0 0
